// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP       := tb_ds18b20
RTL_TOP   := ds18b20_ctrl_top
FILELIST  := ds18b20_ctrl.f
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) hw/ds18b20_pkg.sv \
		hw/onewire_slot_timer.sv hw/onewire_bit_io.sv hw/ds18b20_sequencer.sv \
		hw/ds18b20_apb_regs.sv hw/ds18b20_ctrl_top.sv

clean:
	rm -rf obj_dir $(LOG)

// ==== ds18b20_ctrl.f ====
hw/ds18b20_pkg.sv
hw/onewire_slot_timer.sv
hw/onewire_bit_io.sv
hw/ds18b20_sequencer.sv
hw/ds18b20_apb_regs.sv
hw/ds18b20_ctrl_top.sv
tests/ds18b20_sensor_model.sv
tests/ds18b20_checker.sv
tests/tb_ds18b20.sv

// ==== hw/ds18b20_apb_regs.sv ====
// APB register block with resolution control, status and temperature
`timescale 1ns/1ps

module ds18b20_apb_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [3:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   cfg_req,
    output ds18b20_pkg::res_code_t res_code,
    input  logic                   temp_done,
    input  logic [15:0]            temp_data,
    input  logic                   presence_fault
);
    import ds18b20_pkg::*;

    logic      access;
    logic      addr_ok;
    logic      temp_rd;
    logic      data_valid;
    res_code_t res_last; // code in effect at the last completed read
    logic [15:0] temp_reg;

    assign access  = psel && penable;
    assign addr_ok = (paddr == REG_CTRL) || (paddr == REG_STATUS) || (paddr == REG_TEMP);
    assign pready  = 1'b1;                          // zero-wait slave
    assign pslverr = access && !addr_ok;
    assign cfg_req = access && pwrite && (paddr == REG_CTRL);
    assign temp_rd = access && !pwrite && (paddr == REG_TEMP);

    always_comb begin
        prdata = 32'h0;
        if (psel && !pwrite) begin
            case (paddr)
                REG_CTRL:   prdata = {30'h0, res_code};
                REG_STATUS: prdata = {28'h0, res_last, data_valid, presence_fault};
                REG_TEMP:   prdata = {16'h0, temp_reg};
                default:    prdata = 32'h0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_code   <= 2'd0; // 12 bit, the sensor power-up default
            res_last   <= 2'd0;
            data_valid <= 1'b0;
            temp_reg   <= 16'h0;
        end else begin
            if (cfg_req) begin
                res_code <= pwdata[1:0];
            end
            if (temp_done) begin
                temp_reg   <= temp_data;
                res_last   <= res_code;
                data_valid <= 1'b1; // new sample wins over a same-cycle read
            end else if (temp_rd) begin
                data_valid <= 1'b0;
            end
        end
    end

endmodule

// ==== hw/ds18b20_ctrl_top.sv ====
// DS18B20 one-wire temperature controller top with APB register port
`timescale 1ns/1ps

module ds18b20_ctrl_top #(
    parameter int CONV_PERIOD = 8_000_000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        dq_in,
    output logic        dq_oe
);
    import ds18b20_pkg::*;

    logic              cfg_req;
    res_code_t         res_code;
    logic              temp_done;
    logic [15:0]       temp_data;
    logic              presence_fault;
    seq_state_t        state;
    logic              rx_phase;
    logic [SLOT_W-1:0] slot_cnt;
    logic [2:0]        bit_cnt;
    logic [1:0]        byte_cnt;
    logic              byte_end;
    logic              tx_bit;
    logic              line_sample;
    logic [15:0]       rx_word;

    ds18b20_apb_regs u_regs (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .pready, .pslverr, .cfg_req, .res_code, .temp_done, .temp_data,
        .presence_fault
    );

    ds18b20_sequencer #(.CONV_PERIOD(CONV_PERIOD)) u_seq (
        .clk, .rst_n, .cfg_req, .res_code, .byte_end, .byte_cnt, .bit_cnt,
        .line_sample, .rx_word, .state, .rx_phase, .tx_bit, .temp_done,
        .temp_data, .presence_fault
    );

    onewire_slot_timer u_timer (
        .clk, .rst_n, .state, .rx_phase, .slot_cnt, .bit_cnt, .byte_cnt, .byte_end
    );

    onewire_bit_io u_bit_io (
        .clk, .rst_n, .state, .rx_phase, .slot_cnt, .bit_cnt, .byte_cnt, .tx_bit,
        .dq_in, .dq_oe, .line_sample, .rx_word
    );

endmodule

// ==== hw/ds18b20_pkg.sv ====
// DS18B20 controller shared timing, command and register definitions
package ds18b20_pkg;

    // sequencer phases
    typedef enum logic [2:0] {
        S_IDLE,
        S_INIT,
        S_SKIP_ROM,
        S_SET_CFG,
        S_CONVERT,
        S_READ_TEMP
    } seq_state_t;

    // one-wire function commands
    typedef enum logic [7:0] {
        CMD_SKIP_ROM      = 8'hCC,
        CMD_WRITE_SCRATCH = 8'h4E,
        CMD_CONVERT_T     = 8'h44,
        CMD_READ_SCRATCH  = 8'hBE
    } rom_cmd_t;

    // 0 = 12 bit, 1 = 9 bit, 2 = 10 bit, 3 = 11 bit
    typedef logic [1:0] res_code_t;

    // timing at 10 MHz, 10 cycles per microsecond
    localparam int RESET_LOW_CYC = 5000; // 500 us reset pulse
    localparam int SLOT_CYC      = 800;  // 80 us bit slot
    localparam int WR1_LOW_CYC   = 70;   // write-1 low time
    localparam int WR0_LOW_CYC   = 700;  // write-0 low time
    localparam int RD_LOW_CYC    = 30;   // read slot start pulse
    localparam int RD_SAMPLE_CYC = 120;  // read sample point
    localparam int SLOT_W        = 13;   // fits the reset window

    // scratchpad alarm thresholds
    localparam logic [7:0] ALARM_HIGH = 8'h28;
    localparam logic [7:0] ALARM_LOW  = 8'hF6;

    // APB register map
    localparam logic [3:0] REG_CTRL   = 4'h0;
    localparam logic [3:0] REG_STATUS = 4'h4;
    localparam logic [3:0] REG_TEMP   = 4'h8;

endpackage

// ==== hw/ds18b20_sequencer.sv ====
// DS18B20 transaction sequencer, request flags and transmit byte selection
`timescale 1ns/1ps

module ds18b20_sequencer #(
    parameter int CONV_PERIOD = 8_000_000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cfg_req,
    input  ds18b20_pkg::res_code_t  res_code,
    input  logic                    byte_end,
    input  logic [1:0]              byte_cnt,
    input  logic [2:0]              bit_cnt,
    input  logic                    line_sample,
    input  logic [15:0]             rx_word,
    output ds18b20_pkg::seq_state_t state,
    output logic                    rx_phase,
    output logic                    tx_bit,
    output logic                    temp_done,
    output logic [15:0]             temp_data,
    output logic                    presence_fault
);
    import ds18b20_pkg::*;

    localparam int PER_W = (CONV_PERIOD > 1) ? $clog2(CONV_PERIOD) : 1;

    logic [PER_W-1:0] period_cnt;
    logic             period_end;
    logic             flag_set;
    logic             flag_convert;
    logic             flag_read;
    rom_cmd_t         pass_cmd; // function command of the current pass
    logic [7:0]       send_byte;
    logic             set_done;
    logic             conv_done;
    logic             read_done;

    function automatic logic [7:0] cfg_byte(input res_code_t code);
        case (code)
            2'd1:    cfg_byte = 8'h1F; // 9 bit
            2'd2:    cfg_byte = 8'h3F; // 10 bit
            2'd3:    cfg_byte = 8'h5F; // 11 bit
            default: cfg_byte = 8'h7F; // 12 bit
        endcase
    endfunction

    assign period_end = (period_cnt == PER_W'(CONV_PERIOD - 1));
    assign set_done   = (state == S_SET_CFG) && byte_end;
    assign conv_done  = (state == S_CONVERT) && rx_phase && byte_end && line_sample;
    assign read_done  = (state == S_READ_TEMP) && rx_phase && byte_end;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            period_cnt   <= '0;
            flag_set     <= 1'b0;
            flag_convert <= 1'b0;
            flag_read    <= 1'b0;
        end else begin
            period_cnt <= period_end ? '0 : period_cnt + 1'b1;
            if (cfg_req) begin
                flag_set <= 1'b1;
            end else if (set_done) begin
                flag_set <= 1'b0;
            end
            if (period_end) begin
                flag_convert <= 1'b1;
            end else if (conv_done) begin
                flag_convert <= 1'b0;
            end
            if (conv_done) begin
                flag_read <= 1'b1;     // conversion finished, fetch result
            end else if (read_done) begin
                flag_read <= 1'b0;
            end
        end
    end

    always_comb begin
        case (state)
            S_SKIP_ROM:  send_byte = CMD_SKIP_ROM;
            S_SET_CFG: begin
                case (byte_cnt)
                    2'd0:    send_byte = CMD_WRITE_SCRATCH;
                    2'd1:    send_byte = ALARM_HIGH;
                    2'd2:    send_byte = ALARM_LOW;
                    default: send_byte = cfg_byte(res_code);
                endcase
            end
            S_CONVERT:   send_byte = CMD_CONVERT_T;
            S_READ_TEMP: send_byte = CMD_READ_SCRATCH;
            default:     send_byte = 8'h00;
        endcase
    end

    assign tx_bit = send_byte[bit_cnt]; // LSB first

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= S_IDLE;
            rx_phase       <= 1'b0;
            pass_cmd       <= CMD_CONVERT_T;
            temp_done      <= 1'b0;
            presence_fault <= 1'b0;
        end else begin
            temp_done <= read_done;
            case (state)
                S_IDLE: begin
                    if (flag_set || flag_read || flag_convert) begin
                        state <= S_INIT;
                        // configuration first, then a pending read, then a new conversion
                        if (flag_set) begin
                            pass_cmd <= CMD_WRITE_SCRATCH;
                        end else if (flag_read) begin
                            pass_cmd <= CMD_READ_SCRATCH;
                        end else begin
                            pass_cmd <= CMD_CONVERT_T;
                        end
                    end
                end
                S_INIT: begin
                    if (byte_end) begin
                        rx_phase <= !rx_phase;
                        if (rx_phase && !line_sample) begin
                            state <= S_SKIP_ROM;
                        end else if (rx_phase) begin
                            state          <= S_IDLE; // no presence pulse, retry later
                            presence_fault <= 1'b1;
                        end
                    end
                end
                S_SKIP_ROM: begin
                    if (byte_end) begin
                        case (pass_cmd)
                            CMD_WRITE_SCRATCH: state <= S_SET_CFG;
                            CMD_READ_SCRATCH:  state <= S_READ_TEMP;
                            default:           state <= S_CONVERT;
                        endcase
                    end
                end
                S_SET_CFG: begin
                    if (byte_end) begin
                        state <= S_IDLE;
                    end
                end
                default: begin // convert and read, command byte then read slots
                    if (byte_end && !rx_phase) begin
                        rx_phase <= 1'b1;
                    end else if (conv_done || read_done) begin
                        rx_phase <= 1'b0;
                        state    <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (read_done) begin
            temp_data <= rx_word;
        end
    end

endmodule

// ==== hw/onewire_bit_io.sv ====
// one-wire bit level driver and sampler for reset, write and read slots
`timescale 1ns/1ps

module onewire_bit_io (
    input  logic                           clk,
    input  logic                           rst_n,
    input  ds18b20_pkg::seq_state_t        state,
    input  logic                           rx_phase,
    input  logic [ds18b20_pkg::SLOT_W-1:0] slot_cnt,
    input  logic [2:0]                     bit_cnt,
    input  logic [1:0]                     byte_cnt,
    input  logic                           tx_bit,
    input  logic                           dq_in,
    output logic                           dq_oe,
    output logic                           line_sample,
    output logic [15:0]                    rx_word
);
    import ds18b20_pkg::*;

    logic       drive_low;
    logic       sample_pt;
    logic [3:0] rx_idx;

    always_comb begin
        case (state)
            S_IDLE:  drive_low = 1'b0;
            S_INIT:  drive_low = !rx_phase; // reset pulse, then released for presence
            default: begin
                if (rx_phase) begin
                    drive_low = slot_cnt < SLOT_W'(RD_LOW_CYC);
                end else if (tx_bit) begin
                    drive_low = slot_cnt < SLOT_W'(WR1_LOW_CYC);
                end else begin
                    drive_low = slot_cnt < SLOT_W'(WR0_LOW_CYC);
                end
            end
        endcase
    end

    assign sample_pt = rx_phase && (slot_cnt == SLOT_W'(RD_SAMPLE_CYC));
    assign rx_idx    = {byte_cnt[0], bit_cnt}; // byte_cnt * 8 + bit_cnt

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dq_oe       <= 1'b0;
            line_sample <= 1'b1;
        end else begin
            dq_oe <= drive_low;
            if (state == S_INIT && rx_phase) begin
                // presence window, any low after the line settles counts
                if (slot_cnt == '0) begin
                    line_sample <= 1'b1;
                end else if (slot_cnt > SLOT_W'(RD_SAMPLE_CYC) && !dq_in) begin
                    line_sample <= 1'b0;
                end
            end else if (sample_pt) begin
                line_sample <= dq_in; // busy poll or data bit
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_READ_TEMP && sample_pt) begin
            rx_word[rx_idx] <= dq_in; // LSB first
        end
    end

endmodule

// ==== hw/onewire_slot_timer.sv ====
// one-wire slot timer, chained slot, bit and byte counters with phase limits
`timescale 1ns/1ps

module onewire_slot_timer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  ds18b20_pkg::seq_state_t       state,
    input  logic                          rx_phase,
    output logic [ds18b20_pkg::SLOT_W-1:0] slot_cnt,
    output logic [2:0]                    bit_cnt,
    output logic [1:0]                    byte_cnt,
    output logic                          byte_end
);
    import ds18b20_pkg::*;

    logic [SLOT_W-1:0] slot_last;
    logic [2:0]        bit_last;
    logic [1:0]        byte_last;
    logic              counting;
    logic              slot_end;
    logic              bit_end;

    always_comb begin
        slot_last = SLOT_W'(SLOT_CYC - 1);
        bit_last  = 3'd7;
        byte_last = 2'd0;
        case (state)
            S_INIT:      begin
                slot_last = SLOT_W'(RESET_LOW_CYC - 1); // one long slot per half
                bit_last  = 3'd0;
            end
            S_SET_CFG:   byte_last = 2'd3;              // 4E, TH, TL, config
            S_CONVERT:   bit_last  = rx_phase ? 3'd0 : 3'd7; // single poll slots
            S_READ_TEMP: byte_last = rx_phase ? 2'd1 : 2'd0; // LSB and MSB
            S_IDLE:      begin
                slot_last = '0;
                bit_last  = 3'd0;
            end
            default:     ;
        endcase
    end

    assign counting = (state != S_IDLE);
    assign slot_end = counting && (slot_cnt == slot_last);
    assign bit_end  = slot_end && (bit_cnt == bit_last);
    assign byte_end = bit_end && (byte_cnt == byte_last); // last cycle of the phase

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_cnt <= '0;
            bit_cnt  <= 3'd0;
            byte_cnt <= 2'd0;
        end else if (!counting) begin
            slot_cnt <= '0;
            bit_cnt  <= 3'd0;
            byte_cnt <= 2'd0;
        end else begin
            slot_cnt <= slot_end ? '0 : slot_cnt + 1'b1;
            if (slot_end) begin
                bit_cnt <= bit_end ? 3'd0 : bit_cnt + 3'd1;
            end
            if (bit_end) begin
                byte_cnt <= byte_end ? 2'd0 : byte_cnt + 2'd1;
            end
        end
    end

endmodule

// ==== tests/ds18b20_checker.sv ====
// DS18B20 checker, decodes line bytes from dq_oe and compares line and APB traffic
`timescale 1ns/1ps

module ds18b20_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        dq_oe,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] prdata,
    input  logic        pready,
    input  logic        pslverr,
    input  logic [1:0]  exp_res,
    input  logic [31:0] exp_rdata,
    input  logic [31:0] exp_mask,
    input  logic        exp_slverr,
    input  logic        expect_quiet,
    output int          err_cnt,
    output int          byte_total,
    output int          conv_cnt,
    output int          read_cnt,
    output int          cfg_cnt
);
    import ds18b20_pkg::*;

    int         low_len;
    int         idx;       // byte index since the last reset pulse
    int         nb;
    int         since_rst;
    logic [7:0] shift;
    logic [7:0] pass_cmd;
    logic       read_due;
    logic       cfg_due;   // CTRL written, configuration pass outstanding

    function automatic logic [7:0] cfg_ref(input logic [1:0] code);
        case (code)
            2'd0:    return 8'h7F;
            2'd1:    return 8'h1F;
            2'd2:    return 8'h3F;
            default: return 8'h5F;
        endcase
    endfunction

    // expected byte at position i of a pass whose function command is cmd
    function automatic logic [7:0] seq_ref(input logic [7:0] cmd, input int i,
                                           input logic [1:0] code);
        case (i)
            0:       return 8'hCC;
            1:       return cmd;
            2:       return ALARM_HIGH;
            3:       return ALARM_LOW;
            default: return cfg_ref(code);
        endcase
    endfunction

    task automatic check_byte(input logic [7:0] got);
        logic [7:0] exp;
        byte_total++;
        if (expect_quiet) begin
            $display("command byte 0x%02h sent although no sensor answered", got);
            err_cnt++;
        end
        if (idx == 1) begin
            // a configuration pass only after a CTRL write
            pass_cmd = (cfg_due && got == 8'h4E) ? 8'h4E : (read_due ? 8'hBE : 8'h44);
        end
        if (idx > 4 || (idx > 1 && pass_cmd != 8'h4E)) begin
            $display("extra byte 0x%02h at position %0d of a pass", got, idx);
            err_cnt++;
        end else begin
            exp = seq_ref(pass_cmd, idx, exp_res);
            if (got != exp) begin
                $display("ERR dq_oe byte %0d: got 0x%02h expected 0x%02h", idx, got, exp);
                err_cnt++;
            end
        end
        if (idx == 1 && pass_cmd == 8'h44) begin
            read_due = 1'b1;
            conv_cnt++;
        end else if (idx == 1 && pass_cmd == 8'hBE) begin
            read_due = 1'b0;
            read_cnt++;
        end else if (idx == 1 && pass_cmd == 8'h4E) begin
            cfg_due = 1'b0;
        end else if (idx == 4) begin
            cfg_cnt++;
        end
        idx++;
    endtask

    task automatic classify(input int len);
        if (len > 2 * WR0_LOW_CYC) begin
            if (len != RESET_LOW_CYC) begin
                $display("ERR dq_oe reset width: got 0x%0h expected 0x%0h", len, RESET_LOW_CYC);
                err_cnt++;
            end
            idx = 0;
            nb  = 0;
        end else if (len != RD_LOW_CYC) begin   // read slots carry no data from the DUT
            shift = {(len < WR0_LOW_CYC / 2), shift[7:1]};
            nb++;
            if (nb == 8) begin
                nb = 0;
                check_byte(shift);
            end
        end
    endtask

    initial begin
        err_cnt    = 0;
        byte_total = 0;
        conv_cnt   = 0;
        read_cnt   = 0;
        cfg_cnt    = 0;
        low_len    = 0;
        idx        = 0;
        nb         = 0;
        since_rst  = 0;
        shift      = 8'h0;
        pass_cmd   = 8'h0;
        read_due   = 1'b0;
        cfg_due    = 1'b0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            low_len   = 0;
            since_rst = 0;
        end else begin
            if (since_rst < 100) begin
                since_rst++;
                if (dq_oe) begin
                    $display("ERR dq_oe after reset: got 0x%0h expected 0x0", dq_oe);
                    err_cnt++;
                end
            end
            if (dq_oe) begin
                low_len++;
            end else if (low_len != 0) begin
                classify(low_len);
                low_len = 0;
            end
            if (psel && penable) begin
                if (pready !== 1'b1) begin
                    $display("ERR pready addr 0x%0h: got 0x%0h expected 0x1", paddr, pready);
                    err_cnt++;
                end
                if (pwrite && paddr == REG_CTRL) begin
                    cfg_due = 1'b1;
                end
                if (pslverr != exp_slverr) begin
                    $display("ERR pslverr addr 0x%0h: got 0x%0h expected 0x%0h",
                             paddr, pslverr, exp_slverr);
                    err_cnt++;
                end
                if (!pwrite && ((prdata & exp_mask) != (exp_rdata & exp_mask))) begin
                    $display("ERR prdata addr 0x%0h: got 0x%08h expected 0x%08h",
                             paddr, prdata & exp_mask, exp_rdata & exp_mask);
                    err_cnt++;
                end
            end
        end
    end

endmodule

// ==== tests/ds18b20_sensor_model.sv ====
// DS18B20 behavioral sensor model, answers presence, decodes bytes, returns temperature
`timescale 1ns/1ps

module ds18b20_sensor_model (
    input  logic        dq,
    input  logic        silent,
    output logic        pull,
    output logic [15:0] temp_sent
);
    logic        rd_q[$];   // bits still to return in read slots
    logic [7:0]  shift;
    logic [15:0] temp_cur;
    logic        rd_bit;
    int          nbits;
    int          nbytes;
    int          busy;
    longint      t0;
    longint      width;

    task automatic take_byte(input logic [7:0] data);
        if (nbytes == 1 && data == 8'h44) begin
            temp_cur = 16'($urandom);
            busy     = 1 + int'($urandom % 5);     // polled slots held busy
            repeat (busy) rd_q.push_back(1'b0);
            rd_q.push_back(1'b1);
        end else if (nbytes == 1 && data == 8'hBE) begin
            temp_sent = temp_cur;
            for (int i = 0; i < 16; i++) begin
                rd_q.push_back(temp_cur[i]);       // LSB first
            end
        end
        nbytes++;
    endtask

    initial begin
        pull      = 1'b0;
        temp_sent = 16'h0;
        temp_cur  = 16'h0;
        shift     = 8'h0;
        nbits     = 0;
        nbytes    = 0;
        void'($urandom(38));                       // one seed for the whole run
        forever begin
            @(negedge dq);
            t0 = $time;
            if (rd_q.size() > 0) begin
                rd_bit = rd_q.pop_front();
                if (!rd_bit) begin
                    pull = 1'b1;                   // hold low through the sample point
                    #60000;
                    pull = 1'b0;
                end
                wait (dq == 1'b1);
            end else begin
                @(posedge dq);
                width = $time - t0;
                if (width > 400000) begin          // reset pulse
                    nbits  = 0;
                    nbytes = 0;
                    rd_q.delete();
                    if (!silent) begin
                        #30000;
                        pull = 1'b1;               // presence pulse
                        #120000;
                        pull = 1'b0;
                    end
                end else begin
                    shift = {(width < 35000), shift[7:1]};
                    nbits++;
                    if (nbits == 8) begin
                        nbits = 0;
                        take_byte(shift);
                    end
                end
            end
        end
    end

endmodule

// ==== tests/tb_ds18b20.sv ====
// DS18B20 controller testbench, APB stimulus, sensor model and closing report
`timescale 1ns/1ps

module tb_ds18b20;
    import ds18b20_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        dq_oe;
    logic        dq_line;
    logic        model_pull;
    logic        silent;
    logic [15:0] temp_sent;
    logic [1:0]  exp_res;
    logic [31:0] exp_rdata;
    logic [31:0] exp_mask;
    logic        exp_slverr;
    logic        expect_quiet;
    logic [31:0] rd;
    int          err_cnt;
    int          byte_total;
    int          conv_cnt;
    int          read_cnt;
    int          cfg_cnt;
    int          timeouts;
    int          start_cfg;
    logic [1:0]  codes[4];

    assign dq_line = !(dq_oe || model_pull); // open drain with pull-up

    ds18b20_ctrl_top #(.CONV_PERIOD(20000)) dut0 (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
        .pready, .pslverr, .dq_in(dq_line), .dq_oe
    );

    ds18b20_sensor_model sensor0 (
        .dq(dq_line), .silent, .pull(model_pull), .temp_sent
    );

    ds18b20_checker check0 (
        .clk, .rst_n, .dq_oe, .psel, .penable, .pwrite, .paddr, .prdata, .pready,
        .pslverr, .exp_res, .exp_rdata, .exp_mask, .exp_slverr, .expect_quiet,
        .err_cnt, .byte_total, .conv_cnt, .read_cnt, .cfg_cnt
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] status_ref(input logic fault, input logic valid,
                                               input logic [1:0] code);
        return {28'h0, code, valid, fault};
    endfunction

    task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                              input logic [31:0] exp, input logic [31:0] mask,
                              input logic err, output logic [31:0] got);
        @(negedge clk);
        psel       = 1'b1;
        penable    = 1'b0;
        pwrite     = wr;
        paddr      = addr;
        pwdata     = data;
        exp_rdata  = exp;
        exp_mask   = mask;
        exp_slverr = err;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        got = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_status_bit(input int bit_idx, input int limit);
        int n;
        n  = 0;
        rd = 32'h0;
        while (!rd[bit_idx] && n < limit) begin
            apb_access(1'b0, REG_STATUS, 32'h0, 32'h0, 32'h0, 1'b0, rd);
            n++;
        end
        if (!rd[bit_idx]) begin
            $display("timeout waiting for STATUS bit %0d", bit_idx);
            timeouts++;
        end
    endtask

    task automatic wait_cfg_pass(input int limit);
        int n;
        n = 0;
        while (cfg_cnt == start_cfg && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (cfg_cnt == start_cfg) begin
            $display("timeout waiting for a configuration pass on the line");
            timeouts++;
        end
    endtask

    initial begin
        #100_000_000;
        $display("simulation watchdog expired");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = 4'h0;
        pwdata       = 32'h0;
        silent       = 1'b0;
        exp_res      = 2'd0;
        exp_rdata    = 32'h0;
        exp_mask     = 32'h0;
        exp_slverr   = 1'b0;
        expect_quiet = 1'b0;
        timeouts     = 0;
        codes        = '{2'd1, 2'd2, 2'd3, 2'd0};
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        apb_access(1'b0, REG_STATUS, 32'h0, 32'h0, 32'hFFFF_FFFF, 1'b0, rd);

        // periodic conversion and read
        wait_status_bit(1, 100000);
        apb_access(1'b0, REG_TEMP, 32'h0, {16'h0, temp_sent}, 32'hFFFF_FFFF, 1'b0, rd);
        apb_access(1'b0, REG_STATUS, 32'h0, status_ref(1'b0, 1'b0, 2'd0), 32'hFFFF_FFFF,
                   1'b0, rd);

        foreach (codes[i]) begin
            exp_res   = codes[i];
            start_cfg = cfg_cnt;
            apb_access(1'b1, REG_CTRL, {30'h0, codes[i]}, 32'h0, 32'h0, 1'b0, rd);
            wait_cfg_pass(200000);
            apb_access(1'b0, REG_TEMP, 32'h0, 32'h0, 32'h0, 1'b0, rd); // clear data valid
            wait_status_bit(1, 100000);
            apb_access(1'b0, REG_STATUS, 32'h0, status_ref(1'b0, 1'b1, codes[i]),
                       32'hFFFF_FFFF, 1'b0, rd);
            apb_access(1'b0, REG_TEMP, 32'h0, {16'h0, temp_sent}, 32'hFFFF_FFFF, 1'b0, rd);
        end

        // unmapped address
        apb_access(1'b1, 4'hC, 32'h3, 32'h0, 32'h0, 1'b1, rd);
        apb_access(1'b0, 4'hC, 32'h0, 32'h0, 32'hFFFF_FFFF, 1'b1, rd);
        apb_access(1'b0, REG_CTRL, 32'h0, 32'h0, 32'hFFFF_FFFF, 1'b0, rd);
        apb_access(1'b0, REG_STATUS, 32'h0, status_ref(1'b0, 1'b0, 2'd0), 32'h0000_000C,
                   1'b0, rd);

        // sensor absent
        silent = 1'b1;
        wait_status_bit(0, 200000);
        expect_quiet = 1'b1;
        repeat (50000) @(negedge clk);

        $display("errors=%0d timeouts=%0d bytes=%0d conv=%0d read=%0d cfg=%0d",
                 err_cnt, timeouts, byte_total, conv_cnt, read_cnt, cfg_cnt);
        if (err_cnt == 0 && timeouts == 0 && conv_cnt > 0 && read_cnt > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
